/* Bender.yml */
package:
  name: cpu16_core

sources:
  - design/cpu_pkg.sv
  - design/control_unit.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/pc_counter.sv
  - design/bus_master.sv
  - design/core_fsm.sv
  - design/cpu_top.sv
  - target: test
    files:
      - tests/cpu_sva.sv
      - tests/cpu_tb.sv

/* design/alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_e     op,
    input  logic [15:0] a,     // Source register rs, or rd for jumps
    input  logic [15:0] b,     // Second source rt
    input  logic        c_in,  // Current carry flag
    output logic [15:0] y,
    output flags_t      flags
);

    logic [16:0] sum;   // Extra bit holds the carry out
    logic        c_out;

    always_comb begin
        sum   = 17'd0;
        y     = a;
        c_out = c_in; // Logic ops leave carry alone
        case (op)
            alu_pass: y = a;
            alu_not:  y = ~a;
            alu_inc: begin
                sum   = {1'b0, a} + 17'd1;
                y     = sum[15:0];
                c_out = sum[16];
            end
            alu_dec: begin
                y     = a - 16'd1;
                c_out = (a == 16'd0); // Borrow only when wrapping from zero
            end
            alu_add: begin
                sum   = {1'b0, a} + {1'b0, b};
                y     = sum[15:0];
                c_out = sum[16];
            end
            alu_sub: begin
                y     = a - b;
                c_out = (a < b); // Borrow
            end
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_shl: begin
                y     = {a[14:0], 1'b0};
                c_out = a[15]; // Bit shifted out on the left
            end
            alu_shr: begin
                y     = {1'b0, a[15:1]}; // Logical shift
                c_out = a[0];
            end
            default: y = a;
        endcase
    end

    assign flags.z = (y == 16'd0);
    assign flags.n = y[15];
    assign flags.c = c_out;

endmodule

/* design/bus_master.sv */
`timescale 1ns/1ps

module bus_master import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  wb_req_t     req,      // Taken only while idle
    input  logic [15:0] wb_dat_i,
    input  logic        wb_ack,
    output logic        busy,
    output logic        done,     // One cycle, same cycle as ack
    output logic [15:0] rdata,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [15:0] wb_adr,
    output logic [15:0] wb_dat_o
);

    logic [15:0] rdata_q; // Last word read

    // Cycle control
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (!wb_cyc) begin
            if (req.valid) begin
                wb_cyc <= 1'b1; // cyc and stb rise together
                wb_stb <= 1'b1;
                wb_we  <= req.we;
            end
        end else if (wb_ack) begin
            wb_cyc <= 1'b0; // Dropped the cycle after ack
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    // Address and data held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (!wb_cyc && req.valid) begin
            wb_adr   <= req.addr;
            wb_dat_o <= req.wdata;
        end
        if (wb_cyc && wb_ack) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign busy  = wb_cyc;
    assign done  = wb_cyc & wb_ack;
    assign rdata = done ? wb_dat_i : rdata_q; // Sequencer latches on done

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
    input  opcode_e opcode, // Top five bits of the instruction
    output ctrl_t   ctrl
);

    logic [29:0] pattern; // Same bit order as the decoder table

    // Group boundaries     28|  24|  20|  16|  12|   8|   4|   0|
    always_comb begin
        pattern = 30'b00_0000_0000_0000_0000_0000_0000_0000;
        ctrl    = '0;
        case (opcode)
            op_nop:  pattern = 30'b00_0000_0000_0000_0000_0000_0000_0000;
            op_rti:  pattern = 30'b00_0000_0000_0000_0000_0000_0001_0000; // rti
            op_ret:  pattern = 30'b00_0000_0000_0000_0000_0000_0010_0000; // ret
            op_call: pattern = 30'b00_0000_0000_0000_0000_0000_0100_0000; // call
            op_jmp:  pattern = 30'b00_0000_0000_0000_0000_0000_1000_0001; // jmp, branch
            op_jc:   pattern = 30'b00_0000_0000_0000_0000_0001_0000_0001; // jc, branch
            op_jn:   pattern = 30'b00_0000_0000_0000_0000_0010_0000_0001; // jn, branch
            op_jz:   pattern = 30'b00_0000_0000_0000_0000_0100_0000_0001; // jz, branch
            op_std:  pattern = 30'b00_0000_0000_0000_0000_1000_0000_0010; // std, mem_write
            op_ldd:  pattern = 30'b00_0000_0000_0000_0001_0000_0000_1100; // ldd, mem_read, wb
            op_ldm:  pattern = 30'b00_0000_0000_0000_0010_0000_0000_1000; // ldm, wb
            op_pop:  pattern = 30'b00_0000_0000_0000_0100_0000_0000_1100; // pop, mem_read, wb
            op_push: pattern = 30'b00_0000_0000_0000_1000_0000_0000_0010; // push, mem_write
            op_shr:  pattern = 30'b00_0000_0000_0001_0000_0000_0000_1000; // shr, wb
            op_shl:  pattern = 30'b00_0000_0000_0010_0000_0000_0000_1000; // shl, wb
            op_or:   pattern = 30'b00_0000_0000_0100_0000_0000_0000_1000; // or, wb
            op_and:  pattern = 30'b00_0000_0000_1000_0000_0000_0000_1000; // and, wb
            op_sub:  pattern = 30'b00_0000_0001_0000_0000_0000_0000_1000; // sub, wb
            op_add:  pattern = 30'b00_0000_0010_0000_0000_0000_0000_1000; // add, wb
            op_mov:  pattern = 30'b00_0000_0100_0000_0000_0000_0000_1000; // mov, wb
            op_in:   pattern = 30'b00_0000_1000_0000_0000_0000_0000_1000; // in, wb
            op_out:  pattern = 30'b00_0001_0000_0000_0000_0000_0000_0000; // out
            op_dec:  pattern = 30'b00_0010_0000_0000_0000_0000_0000_1000; // dec, wb
            op_inc:  pattern = 30'b00_0100_0000_0000_0000_0000_0000_1000; // inc, wb
            op_not:  pattern = 30'b00_1000_0000_0000_0000_0000_0000_1000; // not, wb
            op_clrc: pattern = 30'b01_0000_0000_0000_0000_0000_0000_0000; // clrc
            op_setc: pattern = 30'b10_0000_0000_0000_0000_0000_0000_0000; // setc
            default: begin
                // Unused encodings 11011..11111
                pattern = 30'b00_0000_0000_0000_0000_0000_0000_0000;
            end
        endcase
        ctrl = ctrl_t'({1'b0, pattern});
        if (opcode inside {5'b11011, 5'b11100, 5'b11101, 5'b11110, 5'b11111}) begin
            ctrl.illegal = 1'b1; // Only flag set for an undefined opcode
        end
    end

endmodule

/* design/core_fsm.sv */
`timescale 1ns/1ps

module core_fsm import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ctrl_t       ctrl,
    input  logic [15:0] alu_y,
    input  flags_t      alu_flags,
    input  logic [15:0] qa,
    input  logic [15:0] qb,
    input  logic [15:0] pc,
    input  logic        bus_busy,
    input  logic        bus_done,
    input  logic [15:0] bus_rdata,
    input  logic [15:0] in_port,
    output opcode_e     opcode,
    output logic [2:0]  ra,
    output logic [2:0]  rb,
    output logic        rf_we,
    output logic [2:0]  rf_wa,
    output logic [15:0] rf_wd,
    output alu_op_e     alu_op,
    output flags_t      flags,
    output logic        pc_inc,
    output logic        pc_load,
    output logic [15:0] pc_target,
    output wb_req_t     bus_req,
    output logic [15:0] out_port,
    output logic        out_valid,
    output logic        halted
);

    state_e      state;
    logic [15:0] ir;       // Instruction register
    logic [15:0] imm;      // Second word of LDM, LDD, STD
    logic [15:0] res;      // Value written back to rd
    logic [2:0]  rd, rs, rt;
    logic        alu_inst; // Instruction that updates all flags
    logic        halt_op;
    logic        taken;

    assign opcode = opcode_e'(ir[15:11]);
    assign rd = ir[10:8];
    assign rs = ir[7:5];
    assign rt = ir[4:2];

    // OUT and jumps read rd, STD stores rd
    assign ra = (ctrl.out_op | ctrl.branch) ? rd : rs;
    assign rb = ctrl.std ? rd : rt;

    assign alu_inst = ctrl.not_op | ctrl.inc | ctrl.dec | ctrl.add_op | ctrl.sub_op |
                      ctrl.and_op | ctrl.or_op | ctrl.shl | ctrl.shr;
    assign halt_op  = ctrl.push | ctrl.pop | ctrl.call | ctrl.ret | ctrl.rti | ctrl.illegal;
    assign taken    = ctrl.jmp | (ctrl.jz & flags.z) | (ctrl.jn & flags.n) |
                      (ctrl.jc & flags.c);

    always_comb begin
        if (ctrl.not_op)      alu_op = alu_not;
        else if (ctrl.inc)    alu_op = alu_inc;
        else if (ctrl.dec)    alu_op = alu_dec;
        else if (ctrl.add_op) alu_op = alu_add;
        else if (ctrl.sub_op) alu_op = alu_sub;
        else if (ctrl.and_op) alu_op = alu_and;
        else if (ctrl.or_op)  alu_op = alu_or;
        else if (ctrl.shl)    alu_op = alu_shl;
        else if (ctrl.shr)    alu_op = alu_shr;
        else                  alu_op = alu_pass; // MOV copies rs through
    end

    // New request only while the master is idle
    always_comb begin
        bus_req = '0;
        case (state)
            st_fetch, st_fetch_imm: begin
                bus_req.addr  = pc;
                bus_req.valid = !bus_busy;
            end
            st_mem: begin
                bus_req.addr  = imm;
                bus_req.wdata = qb;
                bus_req.we    = ctrl.std;
                bus_req.valid = !bus_busy;
            end
            default: bus_req = '0;
        endcase
    end

    assign pc_inc    = bus_done & ((state == st_fetch) | (state == st_fetch_imm));
    assign pc_load   = (state == st_execute) & taken; // PC already points past the jump
    assign pc_target = qa;
    assign rf_we     = (state == st_writeback) & ctrl.wb;
    assign rf_wa     = rd;
    assign rf_wd     = res;
    assign halted    = (state == st_halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_fetch;
            flags     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                st_fetch: if (bus_done) state <= st_decode;
                st_decode: begin
                    if (halt_op)                            state <= st_halt;
                    else if (ctrl.ldm | ctrl.ldd | ctrl.std) state <= st_fetch_imm;
                    else                                    state <= st_execute;
                end
                st_fetch_imm: if (bus_done) state <= st_execute;
                st_execute: begin
                    if (alu_inst)   flags   <= alu_flags;
                    if (ctrl.setc)  flags.c <= 1'b1;
                    if (ctrl.clrc)  flags.c <= 1'b0;
                    out_valid <= ctrl.out_op; // Pulse lines up with out_port
                    state     <= (ctrl.ldd | ctrl.std) ? st_mem : st_writeback;
                end
                st_mem:       if (bus_done) state <= st_writeback;
                st_writeback: state <= st_fetch;
                default:      state <= st_halt; // Sticky until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && bus_done)     ir  <= bus_rdata;
        if (state == st_fetch_imm && bus_done) imm <= bus_rdata;
        if (state == st_execute) begin
            if (ctrl.in_op)      res <= in_port; // Sampled in execute
            else if (ctrl.ldm)   res <= imm;
            else                 res <= alu_y;
            if (ctrl.out_op)     out_port <= qa;
        end
        if (state == st_mem && bus_done) res <= bus_rdata; // LDD load data
    end

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

    // Opcode field, bits 15..11 of every instruction
    typedef enum logic [4:0] {
        op_nop  = 5'b00000,
        op_setc = 5'b00001,
        op_clrc = 5'b00010,
        op_out  = 5'b00011,
        op_in   = 5'b00100,
        op_push = 5'b00101, // Decoded only, halts the core
        op_pop  = 5'b00110, // Decoded only, halts the core
        op_ldd  = 5'b00111, // Two words, second is the address
        op_jmp  = 5'b01000,
        op_jc   = 5'b01001,
        op_jn   = 5'b01010,
        op_jz   = 5'b01011,
        op_std  = 5'b01100, // Two words, second is the address
        op_call = 5'b01101, // Decoded only, halts the core
        op_ret  = 5'b01110, // Decoded only, halts the core
        op_rti  = 5'b01111, // Decoded only, halts the core
        op_inc  = 5'b10000,
        op_dec  = 5'b10001,
        op_mov  = 5'b10010,
        op_add  = 5'b10011,
        op_not  = 5'b10100,
        op_sub  = 5'b10101,
        op_and  = 5'b10110,
        op_or   = 5'b10111,
        op_shl  = 5'b11000,
        op_shr  = 5'b11001,
        op_ldm  = 5'b11010  // Two words, second is the immediate
    } opcode_e;

    // Declared MSB first, so branch lands on bit 0 and setc on bit 29
    typedef struct packed {
        logic illegal; // Bit 30, opcode outside the table
        logic setc;
        logic clrc;
        logic not_op;
        logic inc;
        logic dec;
        logic out_op;
        logic in_op;
        logic mov;
        logic add_op;
        logic sub_op;
        logic and_op;
        logic or_op;
        logic shl;
        logic shr;
        logic push;
        logic pop;
        logic ldm;
        logic ldd;
        logic std;
        logic jz;
        logic jn;
        logic jc;
        logic jmp;
        logic call;
        logic ret;
        logic rti;
        logic wb;        // Result goes back to rd
        logic mem_read;
        logic mem_write;
        logic branch;    // Bit 0
    } ctrl_t;

    typedef enum logic [3:0] {
        alu_pass, alu_not, alu_inc, alu_dec, alu_add,
        alu_sub, alu_and, alu_or, alu_shl, alu_shr
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_fetch_imm, st_execute, st_mem, st_writeback, st_halt
    } state_e;

    typedef struct packed {
        logic [15:0] addr;  // Word address
        logic [15:0] wdata;
        logic        we;
        logic        valid; // Request present this cycle
    } wb_req_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

endpackage

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [15:0] reset_vector = 16'h0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] in_port,
    output logic [15:0] out_port,
    output logic        out_valid,
    output logic        halted,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [15:0] wb_adr,
    output logic [15:0] wb_dat_o,
    input  logic [15:0] wb_dat_i,
    input  logic        wb_ack
);

    opcode_e     opcode;
    ctrl_t       ctrl;
    alu_op_e     alu_op;
    flags_t      flags;      // Registered flags in the sequencer
    flags_t      alu_flags;  // Flags of the current ALU result
    logic [15:0] alu_y;
    logic [2:0]  ra, rb, rf_wa;
    logic [15:0] qa, qb, rf_wd;
    logic        rf_we;
    logic [15:0] pc, pc_target;
    logic        pc_inc, pc_load;
    wb_req_t     bus_req;
    logic        bus_busy, bus_done;
    logic [15:0] bus_rdata;

    control_unit control_unit_i (.opcode(opcode), .ctrl(ctrl));

    alu alu_i (
        .op(alu_op), .a(qa), .b(qb), .c_in(flags.c), .y(alu_y), .flags(alu_flags)
    );

    reg_file reg_file_i (
        .clk(clk), .rst(rst), .ra(ra), .rb(rb), .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .qa(qa), .qb(qb)
    );

    pc_counter #(.reset_vector(reset_vector)) pc_counter_i (
        .clk(clk), .rst(rst), .inc(pc_inc), .load(pc_load), .target(pc_target), .pc(pc)
    );

    bus_master bus_master_i (
        .clk(clk), .rst(rst), .req(bus_req), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .busy(bus_busy), .done(bus_done), .rdata(bus_rdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o)
    );

    core_fsm core_fsm_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .alu_y(alu_y), .alu_flags(alu_flags),
        .qa(qa), .qb(qb), .pc(pc), .bus_busy(bus_busy), .bus_done(bus_done),
        .bus_rdata(bus_rdata), .in_port(in_port), .opcode(opcode), .ra(ra), .rb(rb),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd), .alu_op(alu_op), .flags(flags),
        .pc_inc(pc_inc), .pc_load(pc_load), .pc_target(pc_target), .bus_req(bus_req),
        .out_port(out_port), .out_valid(out_valid), .halted(halted)
    );

endmodule

/* design/pc_counter.sv */
`timescale 1ns/1ps

module pc_counter #(
    parameter logic [15:0] reset_vector = 16'h0000 // First fetch address
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inc,    // Advance by one word
    input  logic        load,   // Jump taken
    input  logic [15:0] target,
    output logic [15:0] pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (load) begin
            pc <= target; // Load wins over inc
        end else if (inc) begin
            pc <= pc + 16'd1; // Wraps at 16 bits
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  ra,  // Read port A address
    input  logic [2:0]  rb,  // Read port B address
    input  logic        we,
    input  logic [2:0]  wa,
    input  logic [15:0] wd,
    output logic [15:0] qa,
    output logic [15:0] qb
);

    logic [15:0] regs [8]; // R0..R7, no hardwired zero

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: 16'd0};
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads, a write shows up the following cycle
    assign qa = regs[ra];
    assign qb = regs[rb];

endmodule

/* sources.f */
design/cpu_pkg.sv
design/control_unit.sv
design/alu.sv
design/reg_file.sv
design/pc_counter.sv
design/bus_master.sv
design/core_fsm.sv
design/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

/* tests/cpu_sva.sv */
`timescale 1ns/1ps

module cpu_sva #(
    parameter bit bus_side = 1'b1 // Bus protocol checks, else halt checks
) (
    input logic        clk,
    input logic        rst,
    input logic        cyc,
    input logic        stb,
    input logic        we,
    input logic        ack,
    input logic [15:0] adr,
    input logic [15:0] dat_o,
    input logic        halted
);

    int fails = 0; // Count of failed assertions

    if (bus_side) begin : g_bus
        stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
            else begin
                $error("wb_stb high outside a bus cycle");
                fails++;
            end

        // Request held until the slave acks
        req_stable: assert property (@(posedge clk) disable iff (rst)
            stb && !ack |=> $stable(adr) && $stable(we) && $stable(dat_o))
            else begin
                $error("Wishbone request changed before ack");
                fails++;
            end
    end else begin : g_halt
        halt_sticky: assert property (@(posedge clk) halted && !rst |=> halted)
            else begin
                $error("halted fell without reset");
                fails++;
            end

        no_bus_halted: assert property (@(posedge clk) disable iff (rst) halted |-> !cyc)
            else begin
                $error("Bus cycle while halted");
                fails++;
            end
    end

endmodule

bind bus_master cpu_sva #(.bus_side(1'b1)) bus_sva_i (
    .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .ack(wb_ack),
    .adr(wb_adr), .dat_o(wb_dat_o), .halted(1'b0)
);

// busy mirrors wb_cyc inside the sequencer
bind core_fsm cpu_sva #(.bus_side(1'b0)) fsm_sva_i (
    .clk(clk), .rst(rst), .cyc(bus_busy), .stb(1'b0), .we(1'b0), .ack(1'b0),
    .adr(16'h0000), .dat_o(16'h0000), .halted(halted)
);

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int          num_tests   = 9;
    localparam int          prog_words  = 104;             // Longest program the generator builds
    localparam int          cycle_ns    = 8;
    localparam int          test_cycles = prog_words * 12; // Budget per test, in cycles
    localparam logic [15:0] reset_vec   = 16'h0100;        // Low byte zero so it aliases word 0

    logic        clk     = 1'b0;
    logic        rst     = 1'b1;
    logic [15:0] in_port = 16'h0000;
    logic [15:0] out_port;
    logic        out_valid, halted;
    logic        wb_cyc, wb_stb, wb_we;
    logic        wb_ack   = 1'b0;
    logic [15:0] wb_dat_i = 16'h0000;
    logic [15:0] wb_adr, wb_dat_o;

    logic [31:0] lfsr = 32'h21d5c5e0;
    logic [15:0] mem [256];     // Slave memory
    logic [15:0] ref_mem [256]; // Model's own copy of the image
    logic [15:0] exp_out [$];
    logic [15:0] exp_wadr [$];
    logic [15:0] exp_wdat [$];
    logic [15:0] exp_val;
    int          errors = 0;
    int          failed_tests = 0;
    int          n_out, n_wr, addr;
    logic        first_req = 1'b0; // Next cycle is the first fetch after reset
    logic        pending = 1'b0;
    logic [1:0]  wait_left, w;
    string       kind_name [4] = '{"alu", "memory", "jump", "mixed"};
    opcode_e     alu_ops [13] = '{op_nop, op_setc, op_clrc, op_not, op_inc, op_dec, op_mov,
                                  op_add, op_sub, op_and, op_or, op_shl, op_shr};

    cpu_top #(.reset_vector(reset_vec)) dut_i (
        .clk(clk), .rst(rst), .in_port(in_port), .out_port(out_port), .out_valid(out_valid),
        .halted(halted), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always #(cycle_ns / 2) clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [15:0] encode(input opcode_e op, input logic [2:0] rd, rs, rt);
        return {op, rd, rs, rt, 2'b00};
    endfunction

    task automatic put_word(input logic [15:0] word);
        mem[addr]     = word;
        ref_mem[addr] = word;
        addr++;
    endtask

    task automatic build_program(input int kind, input bit last);
        int          cls;
        int          k;
        logic [2:0]  rd;
        logic [15:0] target;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = rand_bits(16); // Data area stays random
            ref_mem[i] = mem[i];
        end
        addr = 0;
        while (addr < prog_words - 8) begin
            cls = rand_bits(3);
            rd  = 3'(rand_bits(3));
            if (cls == 5 && (kind == 1 || kind == 3)) begin
                put_word(encode(rand_bits(1) ? op_std : op_ldd, rd, 3'd0, 3'd0));
                put_word(16'h0080 | rand_bits(4)); // 16 data words so loads hit stores
            end else if (cls == 6 && kind >= 2) begin
                k      = rand_bits(2);
                target = reset_vec + 16'(addr + 3 + k); // Just past the skipped block
                put_word(encode(op_ldm, rd, 3'd0, 3'd0));
                put_word(target);
                put_word(encode(opcode_e'(5'(rand_bits(2)) + 5'd8), rd, 3'd0, 3'd0)); // JMP..JZ
                repeat (k) put_word(encode(op_out, 3'(rand_bits(3)), 3'd0, 3'd0));
            end else if (cls == 4) begin
                put_word(encode(op_ldm, rd, 3'd0, 3'd0));
                put_word(rand_bits(16));
            end else if (cls == 3 || (cls == 7 && kind != 3)) begin
                put_word(encode(op_out, rd, 3'd0, 3'd0));
            end else if (cls == 7) begin
                put_word(encode(op_in, rd, 3'd0, 3'd0));
            end else begin
                put_word(encode(alu_ops[rand_bits(4) % 13], rd, 3'(rand_bits(3)),
                                3'(rand_bits(3))));
            end
        end
        if (last) begin
            put_word(encode(opcode_e'(5'd27 + 5'(rand_bits(3) % 5)), 3'd0, 3'd0, 3'd0));
        end else begin
            put_word(encode(op_push, 3'd0, 3'd0, 3'd0));
        end
    endtask

    // Instruction set model, fills the expected OUT and write queues
    task automatic run_model(input logic [15:0] in_val);
        logic [15:0] r [8];
        logic [15:0] pc, ir, imm, a, b, y;
        logic [2:0]  rd;
        logic        z, n, c, upd, stop;
        r    = '{default: 16'd0};
        pc   = reset_vec;
        z    = 1'b0;
        n    = 1'b0;
        c    = 1'b0;
        stop = 1'b0;
        while (!stop) begin
            ir  = ref_mem[pc[7:0]];
            pc  = pc + 16'd1;
            imm = ref_mem[pc[7:0]]; // Used by two-word instructions only
            rd  = ir[10:8];
            a   = r[ir[7:5]];
            b   = r[ir[4:2]];
            y   = a;
            upd = 1'b1;             // Cleared below for anything but ALU ops
            case (ir[15:11])
                op_not: y = ~a;
                op_inc: {c, y} = {1'b0, a} + 17'd1;
                op_dec: begin
                    y = a - 16'd1;
                    c = (a == 16'd0);
                end
                op_add: {c, y} = {1'b0, a} + {1'b0, b};
                op_sub: begin
                    y = a - b;
                    c = (b > a);    // Borrow
                end
                op_and: y = a & b;
                op_or:  y = a | b;
                op_shl: {c, y} = {a, 1'b0};
                op_shr: {y, c} = {1'b0, a};
                default: upd = 1'b0;
            endcase
            case (ir[15:11])
                op_nop, op_not, op_inc, op_dec, op_add, op_sub, op_and, op_or, op_shl, op_shr: ;
                op_setc: c = 1'b1;
                op_clrc: c = 1'b0;
                op_out:  exp_out.push_back(r[rd]);
                op_in:   r[rd] = in_val;
                op_mov:  r[rd] = a;
                op_ldm: begin
                    r[rd] = imm;
                    pc    = pc + 16'd1;
                end
                op_ldd: begin
                    r[rd] = ref_mem[imm[7:0]];
                    pc    = pc + 16'd1;
                end
                op_std: begin
                    ref_mem[imm[7:0]] = r[rd];
                    exp_wadr.push_back(imm);
                    exp_wdat.push_back(r[rd]);
                    pc = pc + 16'd1;
                end
                op_jmp: pc = r[rd];
                op_jz:  if (z) pc = r[rd];
                op_jn:  if (n) pc = r[rd];
                op_jc:  if (c) pc = r[rd];
                default: stop = 1'b1; // Stack, interrupt or undefined opcode
            endcase
            if (upd) begin
                r[rd] = y;
                z     = (y == 16'd0);
                n     = y[15];
            end
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            pending <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;                       // Master drops cyc on this edge
        end else if (wb_cyc && wb_stb) begin
            w = pending ? wait_left : 2'(rand_bits(2));
            if (w == 2'd0) begin
                wb_ack   <= 1'b1;
                pending  <= 1'b0;
                wb_dat_i <= mem[wb_adr[7:0]];
                if (wb_we) mem[wb_adr[7:0]] = wb_dat_o;
            end else begin
                pending   <= 1'b1;
                wait_left <= w - 2'd1;
            end
        end
    end

    // OUT and bus write checks, in program order
    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (exp_out.size() == 0) begin
                $display("ERROR: OUT of %h at %0t ns when no OUT was expected", out_port, $time);
                errors++;
            end else begin
                exp_val = exp_out.pop_front();
                n_out++;
                if (out_port !== exp_val) begin
                    $display("FAILED at %0t ns: out_port got %h, expected %h",
                             $time, out_port, exp_val);
                    errors++;
                end
            end
        end
        if (!rst && wb_cyc && wb_stb && wb_ack && wb_we) begin
            if (exp_wadr.size() == 0) begin
                $display("ERROR: bus write to %h at %0t ns was not expected", wb_adr, $time);
                errors++;
            end else begin
                exp_val = exp_wadr.pop_front();
                if (wb_adr !== exp_val) begin
                    $display("FAILED at %0t ns: wb_adr got %h, expected %h", $time, wb_adr, exp_val);
                    errors++;
                end
                exp_val = exp_wdat.pop_front();
                if (wb_dat_o !== exp_val) begin
                    $display("FAILED at %0t ns: wb_dat_o got %h, expected %h",
                             $time, wb_dat_o, exp_val);
                    errors++;
                end
                n_wr++;
            end
        end
        if (!rst && first_req && wb_cyc) begin
            first_req = 1'b0;
            if (wb_adr !== reset_vec) begin
                $display("FAILED at %0t ns: wb_adr got %h, expected %h", $time, wb_adr, reset_vec);
                errors++;
            end
            if (wb_we) begin
                $display("ERROR: first bus cycle after reset is a write");
                errors++;
            end
        end
    end

    initial begin
        int          base_err;
        int          halt_wait;
        int          sva_total;
        int          sva_seen = 0;
        logic [15:0] in_val;
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            in_val = rand_bits(16);
            rst     <= 1'b1;
            in_port <= in_val;
            base_err = errors;
            n_out    = 0;
            n_wr     = 0;
            exp_out.delete();
            exp_wadr.delete();
            exp_wdat.delete();
            build_program(t % 4, t == num_tests - 1); // Last one halts on an undefined opcode
            run_model(in_val);
            @(posedge clk);
            @(negedge clk);
            if (wb_cyc || wb_stb || wb_we || out_valid || halted) begin
                $display("ERROR: bus or status outputs not low during reset at %0t ns", $time);
                errors++;
            end
            first_req = 1'b1;
            @(posedge clk);
            rst <= 1'b0;
            halt_wait = 0;
            while (!halted && halt_wait < test_cycles) begin
                @(negedge clk);
                halt_wait++;
            end
            if (!halted) begin
                $display("ERROR: test %0d did not halt within %0d cycles", t, test_cycles);
                errors++;
            end
            repeat (20) begin               // Core must stay off the bus once halted
                @(negedge clk);
                if (wb_cyc) begin
                    $display("ERROR: bus cycle started after halt at %0t ns", $time);
                    errors++;
                end
            end
            if (exp_out.size() != 0 || exp_wadr.size() != 0) begin
                $display("ERROR: test %0d ended with %0d OUT values and %0d writes missing",
                         t, exp_out.size(), exp_wadr.size());
                errors++;
            end
            sva_total = dut_i.bus_master_i.bus_sva_i.fails + dut_i.core_fsm_i.fsm_sva_i.fails;
            if (sva_total != sva_seen) begin
                $display("ERROR: %0d assertion failures during test %0d",
                         sva_total - sva_seen, t);
                errors   += sva_total - sva_seen;
                sva_seen  = sva_total;
            end
            if (errors != base_err) failed_tests++;
            $display("test %0d %s: %0d OUT, %0d writes, %0d cycles, %0d errors",
                     t, kind_name[t % 4], n_out, n_wr, halt_wait, errors - base_err);
        end
        $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the per-test budget
    initial begin
        #(num_tests * (test_cycles + 40) * cycle_ns);
        $display("ERROR: watchdog expired at %0t ns, run stopped", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule
